//--- Makefile
TOP := idct_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/idct_asserts.sv
`timescale 1ns/100ps

module idct_asserts #(
	parameter int CREDITS = 4,
	parameter int CNT_W = 3
) (
	input logic Clock,
	input logic Resetn,
	input logic out_valid,
	input logic out_credit,
	input logic [CNT_W-1:0] credit_cnt
);

	int credits_held; // Credits as seen at the ports

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			credits_held <= CREDITS;
		end else begin
			credits_held <= credits_held + int'(out_credit) - int'(out_valid);
		end
	end

	credit_bound: assert property (@(posedge Clock) disable iff (!Resetn)
		credit_cnt <= CNT_W'(CREDITS))
		else $error("Credit count above the granted credits");

	valid_needs_credit: assert property (@(posedge Clock) disable iff (!Resetn)
		out_valid |-> (credits_held > 0))
		else $error("out_valid high with no credit left");

	// Covers the whole reset and the first edge after it
	quiet_after_reset: assert property (@(posedge Clock)
		(!Resetn || $rose(Resetn)) |-> !out_valid)
		else $error("out_valid high in or right after reset");

endmodule

bind idct_out_buf idct_asserts #(
	.CREDITS (CREDITS),
	.CNT_W   (CNT_W)
) i_asserts (
	.Clock      (Clock),
	.Resetn     (Resetn),
	.out_valid  (out_valid),
	.out_credit (out_credit),
	.credit_cnt (credit_cnt)
);

//--- bench/idct_tb.sv
`timescale 1ns/100ps

`include "idct_defs.svh"

module idct_tb;

	localparam int N = `IDCT_N;
	localparam int BLOCKS = 7;
	localparam int BLOCK_CYCLES = 1200; // Load, both passes and drains
	localparam int TIMEOUT_CYCLES = BLOCKS * BLOCK_CYCLES + 1000;

	logic Clock = 1'b0;
	logic Resetn = 1'b0;
	logic in_valid = 1'b0;
	logic signed [`COEF_W-1:0] in_data = '0;
	logic in_ready;
	logic out_valid;
	logic signed [`COEF_W-1:0] out_data;
	logic out_credit = 1'b0;

	int seed = 32'h5bba;
	int gap_seed = 32'h5bba; // Credit gaps draw from their own stream
	int stim [N*N];
	int exp_q [$];
	string cur_test = "reset";
	int beats_seen = 0;
	int returned = 0; // Credits handed back to the DUT
	bit credit_on = 1'b1;
	int cycle_cnt = 0;
	int hold_base;
	int last_of_block;

	idct_top i_dut (
		.Clock      (Clock),
		.Resetn     (Resetn),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_credit (out_credit)
	);

	always #10 Clock = ~Clock;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input int expected, input int actual);
		assert (expected == actual) else begin
			abort_run($sformatf("** Error [%s] %s: expected %0d, actual %0d",
				cur_test, what, expected, actual));
		end
	endtask

	function automatic int cos_coef(input int k, input int n);
		int m;
		int mag;
		bit neg;
		m = ((2 * n + 1) * k) % 32;
		if (m > 16) begin
			m = 32 - m;
		end
		neg = (m > 8);
		if (neg) begin
			m = 16 - m;
		end
		case (m)
			1: mag = 2008;
			2: mag = 1892;
			3: mag = 1702;
			4: mag = 1448;
			5: mag = 1137;
			6: mag = 783;
			7: mag = 399;
			default: mag = 0;
		endcase
		if (k == 0) begin
			return 1448;
		end
		return neg ? -mag : mag;
	endfunction

	// Both passes on 32-bit ints with row-major results appended to the queue
	function automatic void expect_block(input int blk [N*N]);
		int t [N*N];
		int acc;
		logic signed [`COEF_W-1:0] r16;
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				acc = 0;
				for (int k = 0; k < N; k++) begin
					acc += blk[i*N + k] * cos_coef(k, j);
				end
				t[i*N + j] = acc >>> 8;
			end
		end
		for (int i = 0; i < N; i++) begin
			for (int j = 0; j < N; j++) begin
				acc = 0;
				for (int k = 0; k < N; k++) begin
					acc += cos_coef(k, i) * t[k*N + j];
				end
				r16 = `COEF_W'(acc >>> 16);
				exp_q.push_back(int'(r16));
			end
		end
	endfunction

	task automatic next_cycle;
		@(posedge Clock);
		#2;
	endtask

	task automatic send_block(input int blk [N*N]);
		bit taken;
		for (int idx = 0; idx < N*N; idx++) begin
			in_valid = 1'b1;
			in_data = `COEF_W'(blk[idx]);
			taken = 1'b0;
			while (!taken) begin
				taken = in_ready; // Stable until the next edge
				next_cycle();
			end
		end
		in_valid = 1'b0;
	endtask

	task automatic make_random_block;
		for (int idx = 0; idx < N*N; idx++) begin
			stim[idx] = $random(seed) % 1024; // Small enough for 32-bit passes
		end
	endtask

	task automatic make_dc_block;
		for (int idx = 0; idx < N*N; idx++) begin
			stim[idx] = 0;
		end
		stim[0] = 1024;
	endtask

	task automatic wait_drained;
		while (exp_q.size() != 0 || beats_seen != returned) begin
			next_cycle();
		end
	endtask

	always @(negedge Clock) begin
		if (Resetn && out_valid) begin
			if (exp_q.size() == 0) begin
				abort_run("An output beat arrived with no block pending");
			end else begin
				check_value($sformatf("beat %0d", beats_seen), exp_q.pop_front(),
					int'(out_data));
				beats_seen++;
			end
		end
	end

	always @(posedge Clock) begin
		#2;
		if (credit_on && beats_seen > returned && ($random(gap_seed) & 3) != 0) begin
			out_credit = 1'b1;
			returned++;
		end else begin
			out_credit = 1'b0;
		end
	end

	always @(posedge Clock) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			abort_run($sformatf("Timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
		end
	end

	initial begin
		repeat (5) @(posedge Clock);
		#2;
		Resetn = 1'b1;

		cur_test = "reset_state";
		check_value("out_valid", 0, int'(out_valid));
		check_value("in_ready", 1, int'(in_ready));

		cur_test = "dc_block";
		make_dc_block();
		expect_block(stim);
		send_block(stim);
		wait_drained();

		cur_test = "random_back_to_back";
		repeat (3) begin
			make_random_block();
			expect_block(stim);
			send_block(stim);
		end
		wait_drained();

		cur_test = "credit_hold";
		credit_on = 1'b0;
		hold_base = beats_seen;
		make_random_block();
		expect_block(stim);
		send_block(stim);
		while (beats_seen < hold_base + `OUT_CREDITS) begin
			next_cycle();
		end
		while (i_dut.free_slots >= 2) begin
			next_cycle(); // FIFO nearly full so ctrl is about to stall
		end
		repeat (20) next_cycle(); // Two column groups plus pipeline
		check_value("beats with credits held", `OUT_CREDITS, beats_seen - hold_base);
		credit_on = 1'b1;
		wait_drained();

		cur_test = "ready_reload";
		make_random_block();
		expect_block(stim);
		send_block(stim);
		check_value("in_ready after 64 beats", 0, int'(in_ready));
		last_of_block = beats_seen + N*N;
		while (!in_ready) begin
			next_cycle();
		end
		assert (beats_seen < last_of_block) else begin
			abort_run("in_ready rose only after the whole block had left");
		end
		make_random_block();
		expect_block(stim);
		send_block(stim);
		wait_drained();

		if (exp_q.size() == 0 && beats_seen == BLOCKS * N * N) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			abort_run("The run ended with missing or extra output beats");
		end
	end

endmodule

//--- filelist.f
+incdir+hw
hw/idct_pkg.sv
hw/idct_ctrl.sv
hw/idct_coef_rom.sv
hw/idct_block_mem.sv
hw/idct_mac.sv
hw/idct_out_buf.sv
hw/idct_top.sv
bench/idct_asserts.sv
bench/idct_tb.sv

//--- hw/idct_block_mem.sv
`timescale 1ns/100ps

`include "idct_defs.svh"

module idct_block_mem
	import idct_pkg::*;
(
	input  logic Clock,
	input  logic Resetn,
	input  logic load_we,
	input  logic [5:0] load_addr,
	input  logic signed [`COEF_W-1:0] in_data,
	input  idct_term_t term,
	input  logic term_valid,
	input  idct_result_t result,
	input  logic result_valid,
	output idct_operand_t operand,
	output logic operand_valid
);

	logic signed [`COEF_W-1:0] s_mem [`IDCT_N * `IDCT_N]; // Input coefficients
	logic signed [`ACC_W-1:0] t_mem [`IDCT_N * `IDCT_N]; // Row pass results

	logic t_we;
	logic signed [`ACC_W-1:0] rd_data;

	assign t_we = result_valid && (result.pass == ROW);

	always_comb begin
		if (term.pass == ROW) begin
			rd_data = `ACC_W'(s_mem[{term.i, term.k}]); // S[i][k]
		end else begin
			rd_data = t_mem[{term.k, term.j}]; // T[k][j]
		end
	end

	always_ff @(posedge Clock) begin
		if (load_we) begin
			s_mem[load_addr] <= in_data;
		end
		if (t_we) begin
			t_mem[{result.i, result.j}] <= result.value;
		end
		if (term_valid) begin
			operand.data <= rd_data;
			operand.cos <= '0; // Filled from the rom at the mac
			operand.pass <= term.pass;
			operand.i <= term.i;
			operand.j <= term.j;
			operand.first <= term.first;
			operand.last <= term.last;
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			operand_valid <= 1'b0;
		end else begin
			operand_valid <= term_valid;
		end
	end

endmodule

//--- hw/idct_coef_rom.sv
`timescale 1ns/100ps

`include "idct_defs.svh"

module idct_coef_rom
	import idct_pkg::*;
(
	input  logic Clock,
	input  logic Resetn,
	input  idct_term_t term,
	output logic signed [`COS_W-1:0] cos_val
);

	logic [2:0] n;
	logic [4:0] m_raw;
	logic [4:0] m_fold;
	logic [4:0] m_mag;
	logic neg;
	logic [`COS_W-1:0] mag;
	logic signed [`COS_W-1:0] cos_next;

	always_comb begin
		n = (term.pass == ROW) ? term.j : term.i; // C[k][j] rows, C[k][i] columns
		m_raw = 5'({2'b00, n, 1'b1} * {3'b000, term.k}); // (2n+1)k mod 32
		m_fold = (m_raw > 5'd16) ? 5'd0 - m_raw : m_raw;
		neg = (m_fold > 5'd8);
		m_mag = neg ? 5'd16 - m_fold : m_fold;
		case (m_mag)
			5'd1: mag = `COS_W'd2008;
			5'd2: mag = `COS_W'd1892;
			5'd3: mag = `COS_W'd1702;
			5'd4: mag = `COS_W'd1448;
			5'd5: mag = `COS_W'd1137;
			5'd6: mag = `COS_W'd783;
			5'd7: mag = `COS_W'd399;
			default: mag = '0;
		endcase
		if (term.k == 3'd0) begin
			cos_next = `COS_W'sd1448; // DC row is flat
		end else begin
			cos_next = neg ? -$signed(mag) : $signed(mag);
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			cos_val <= '0;
		end else begin
			cos_val <= cos_next;
		end
	end

endmodule

//--- hw/idct_ctrl.sv
`timescale 1ns/100ps

`include "idct_defs.svh"

module idct_ctrl
	import idct_pkg::*;
(
	input  logic Clock,
	input  logic Resetn,
	input  logic in_valid,
	input  logic [`SLOT_W-1:0] free_slots,
	output logic in_ready,
	output logic load_we,
	output logic [5:0] load_addr,
	output idct_term_t term,
	output logic term_valid
);

	typedef enum logic [2:0] {
		S_LOAD,
		S_ROW,
		S_DRAIN_ROW,
		S_COL,
		S_DRAIN_COL
	} state_t;

	localparam logic [5:0] LOAD_LAST = 6'(`IDCT_N * `IDCT_N - 1);
	localparam logic [2:0] K_LAST = 3'(`IDCT_N - 1);
	localparam logic [1:0] DRAIN_LAST = 2'd2;
	localparam logic [`SLOT_W-1:0] GROUP_SLOTS = 2; // Group in flight plus the next one

	state_t state;
	logic [5:0] load_cnt;
	logic [8:0] term_cnt; // {i, j, k}
	logic [1:0] drain_cnt;
	logic col_stall;
	logic issue;
	idct_term_t next_term;

	assign in_ready = (state == S_LOAD);
	assign load_we = in_valid && in_ready;
	assign load_addr = load_cnt;

	assign col_stall = (term_cnt[2:0] == 3'd0) && (free_slots < GROUP_SLOTS);
	assign issue = (state == S_ROW) || ((state == S_COL) && !col_stall);

	always_comb begin
		next_term.pass = (state == S_COL) ? COL : ROW;
		next_term.i = term_cnt[8:6];
		next_term.j = term_cnt[5:3];
		next_term.k = term_cnt[2:0];
		next_term.first = (term_cnt[2:0] == 3'd0);
		next_term.last = (term_cnt[2:0] == K_LAST);
	end

	always_ff @(posedge Clock) begin
		if (issue) begin
			term <= next_term;
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			state <= S_LOAD;
			load_cnt <= '0;
			term_cnt <= '0;
			drain_cnt <= '0;
			term_valid <= 1'b0;
		end else begin
			term_valid <= issue;
			if (issue) begin
				term_cnt <= term_cnt + 9'd1; // Wraps to 0 at end of pass
			end
			case (state)
				S_LOAD: begin
					if (load_we) begin
						load_cnt <= load_cnt + 6'd1;
						if (load_cnt == LOAD_LAST) begin
							state <= S_ROW;
						end
					end
				end
				S_ROW, S_COL: begin
					if (issue && (&term_cnt)) begin
						state <= (state == S_ROW) ? S_DRAIN_ROW : S_DRAIN_COL;
					end
				end
				S_DRAIN_ROW, S_DRAIN_COL: begin
					if (drain_cnt == DRAIN_LAST) begin
						drain_cnt <= '0;
						state <= (state == S_DRAIN_ROW) ? S_COL : S_LOAD;
					end else begin
						drain_cnt <= drain_cnt + 2'd1;
					end
				end
				default: state <= S_LOAD;
			endcase
		end
	end

endmodule

//--- hw/idct_defs.svh
`ifndef IDCT_DEFS_SVH
`define IDCT_DEFS_SVH

`define IDCT_N 8
`define COEF_W 16
`define COS_W 12
`define ACC_W 32

`define ROW_SHIFT 8
`define COL_SHIFT 16

`define OUT_CREDITS 4
`define OUT_DEPTH 8
// Wide enough to hold 0 up to OUT_DEPTH
`define SLOT_W $clog2(`OUT_DEPTH + 1)

`endif

//--- hw/idct_mac.sv
`timescale 1ns/100ps

`include "idct_defs.svh"

module idct_mac
	import idct_pkg::*;
(
	input  logic Clock,
	input  logic Resetn,
	input  idct_operand_t operand,
	input  logic operand_valid,
	input  logic signed [`COS_W-1:0] cos_val,
	output idct_result_t result,
	output logic result_valid
);

	idct_operand_t op;
	logic signed [`ACC_W-1:0] product;
	logic signed [`ACC_W-1:0] sum;
	logic signed [`ACC_W-1:0] acc;

	always_comb begin
		op = operand;
		op.cos = cos_val; // Rom cosine joins the data here
	end

	assign product = op.data * `ACC_W'(op.cos); // Keeps low 32 bits
	assign sum = op.first ? product : acc + product;

	always_ff @(posedge Clock) begin
		if (operand_valid) begin
			acc <= sum;
		end
		if (operand_valid && op.last) begin
			result.pass <= op.pass;
			result.i <= op.i;
			result.j <= op.j;
			result.value <= (op.pass == COL) ? sum >>> `COL_SHIFT : sum >>> `ROW_SHIFT;
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= operand_valid && op.last;
		end
	end

endmodule

//--- hw/idct_out_buf.sv
`timescale 1ns/100ps

`include "idct_defs.svh"

module idct_out_buf
	import idct_pkg::*;
#(
	parameter int CREDITS = `OUT_CREDITS
) (
	input  logic Clock,
	input  logic Resetn,
	input  idct_result_t result,
	input  logic result_valid,
	input  logic out_credit,
	output logic out_valid,
	output logic signed [`COEF_W-1:0] out_data,
	output logic [`SLOT_W-1:0] free_slots
);

	localparam int PTR_W = $clog2(`OUT_DEPTH);
	localparam int FILL_W = `SLOT_W;
	localparam int CNT_W = $clog2(CREDITS + 1);
	localparam logic [FILL_W-1:0] DEPTH = `OUT_DEPTH;

	logic signed [`COEF_W-1:0] fifo_mem [`OUT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [FILL_W-1:0] count;
	logic [CNT_W-1:0] credit_cnt;
	logic push;
	logic pop;

	assign push = result_valid && (result.pass == COL);
	assign pop = (count != '0) && (credit_cnt != '0);

	assign out_valid = pop;
	assign out_data = fifo_mem[rd_ptr];
	assign free_slots = DEPTH - count;

	always_ff @(posedge Clock) begin
		if (push) begin
			fifo_mem[wr_ptr] <= result.value[`COEF_W-1:0]; // Low 16 bits of R
		end
	end

	always_ff @(posedge Clock or negedge Resetn) begin
		if (!Resetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_cnt <= CNT_W'(CREDITS);
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + FILL_W'(push) - FILL_W'(pop);
			credit_cnt <= credit_cnt + CNT_W'(out_credit) - CNT_W'(pop);
		end
	end

endmodule

//--- hw/idct_pkg.sv
`include "idct_defs.svh"

package idct_pkg;

	typedef enum logic {ROW = 1'b0, COL = 1'b1} pass_t;

	typedef struct packed {
		pass_t pass;
		logic [2:0] i;
		logic [2:0] j;
		logic [2:0] k;
		logic first;
		logic last;
	} idct_term_t;

	typedef struct packed {
		logic signed [`ACC_W-1:0] data;
		logic signed [`COS_W-1:0] cos;
		pass_t pass;
		logic [2:0] i;
		logic [2:0] j;
		logic first;
		logic last;
	} idct_operand_t;

	typedef struct packed {
		pass_t pass;
		logic [2:0] i;
		logic [2:0] j;
		logic signed [`ACC_W-1:0] value;
	} idct_result_t;

endpackage

//--- hw/idct_top.sv
`timescale 1ns/100ps

`include "idct_defs.svh"

module idct_top
	import idct_pkg::*;
(
	input  logic Clock,
	input  logic Resetn,
	input  logic in_valid,
	input  logic signed [`COEF_W-1:0] in_data,
	output logic in_ready,
	output logic out_valid,
	output logic signed [`COEF_W-1:0] out_data,
	input  logic out_credit
);

	idct_term_t term;
	logic term_valid;
	logic load_we;
	logic [5:0] load_addr;
	logic [`SLOT_W-1:0] free_slots;
	logic signed [`COS_W-1:0] cos_val;
	idct_operand_t operand;
	logic operand_valid;
	idct_result_t result;
	logic result_valid;

	idct_ctrl i_ctrl (
		.Clock      (Clock),
		.Resetn     (Resetn),
		.in_valid   (in_valid),
		.free_slots (free_slots),
		.in_ready   (in_ready),
		.load_we    (load_we),
		.load_addr  (load_addr),
		.term       (term),
		.term_valid (term_valid)
	);

	idct_coef_rom i_coef_rom (
		.Clock   (Clock),
		.Resetn  (Resetn),
		.term    (term),
		.cos_val (cos_val)
	);

	idct_block_mem i_block_mem (
		.Clock         (Clock),
		.Resetn        (Resetn),
		.load_we       (load_we),
		.load_addr     (load_addr),
		.in_data       (in_data),
		.term          (term),
		.term_valid    (term_valid),
		.result        (result),
		.result_valid  (result_valid),
		.operand       (operand),
		.operand_valid (operand_valid)
	);

	idct_mac i_mac (
		.Clock         (Clock),
		.Resetn        (Resetn),
		.operand       (operand),
		.operand_valid (operand_valid),
		.cos_val       (cos_val),
		.result        (result),
		.result_valid  (result_valid)
	);

	idct_out_buf #(
		.CREDITS (`OUT_CREDITS)
	) i_out_buf (
		.Clock        (Clock),
		.Resetn       (Resetn),
		.result       (result),
		.result_valid (result_valid),
		.out_credit   (out_credit),
		.out_valid    (out_valid),
		.out_data     (out_data),
		.free_slots   (free_slots)
	);

endmodule
